/* logic/btb_params.svh */
// Size and width macros shared by the branch target buffer blocks
`ifndef BTB_PARAMS_SVH
`define BTB_PARAMS_SVH

// pc counted in halfwords
`define BTB_PC_WIDTH        38

// eight lanes per fetch block
`define BTB_LOG_FETCH_LANES 3

// 128 sets, two ways each
`define BTB_LOG_SETS        7
`define BTB_ASSOC           2

// address space id
`define BTB_ASID_WIDTH      9

// entry fields
`define BTB_TAG_WIDTH       8
`define BTB_ACTION_WIDTH    3
`define BTB_TARGET_WIDTH    18

`endif

/* logic/btb_pkg.sv */
// Types and pc field helpers for the branch target buffer
`include "btb_params.svh"

package btb_pkg;

    // --------------------
    // address fields

    typedef logic [`BTB_PC_WIDTH-1:0]        pc_t;
    typedef logic [`BTB_ASID_WIDTH-1:0]      asid_t;
    typedef logic [`BTB_LOG_SETS-1:0]        fetch_idx_t;
    typedef logic [`BTB_LOG_FETCH_LANES-1:0] lane_t;

    // hashed lookup fields
    typedef logic [`BTB_LOG_SETS-1:0]        btb_idx_t;
    typedef logic [`BTB_TAG_WIDTH-1:0]       btb_tag_t;
    typedef logic [$clog2(`BTB_ASSOC)-1:0]   way_idx_t;

    // --------------------
    // stored entries

    // action of zero marks the entry empty
    typedef struct packed {
        logic [`BTB_ACTION_WIDTH-1:0] action;
        logic [`BTB_TARGET_WIDTH-1:0] target;
    } btb_info_t;

    // four bytes per entry
    typedef struct packed {
        btb_info_t info;
        btb_tag_t  tag;
        lane_t     lane;
    } btb_entry_t;

    // way 1 sits in the upper half
    typedef btb_entry_t [`BTB_ASSOC-1:0] btb_set_t;

    // tree bits, one per internal node
    typedef logic [`BTB_ASSOC-2:0] btb_plru_t;

    // --------------------
    // pc field extraction

    // fetch block index just above the lane bits
    function automatic fetch_idx_t fetch_idx_bits(input pc_t pc);
        fetch_idx_bits = pc[`BTB_LOG_SETS+`BTB_LOG_FETCH_LANES-1:`BTB_LOG_FETCH_LANES];
    endfunction

    // lane within the fetch block
    function automatic lane_t fetch_lane_bits(input pc_t pc);
        fetch_lane_bits = pc[`BTB_LOG_FETCH_LANES-1:0];
    endfunction

endpackage

/* logic/btb_update_if.sv */
// Update request bundle from the predictor into the branch target buffer
`timescale 1ns/1ps

interface btb_update_if;

    // single cycle strobe, rest is qualified by it
    logic                 update_valid;
    btb_pkg::pc_t         update_pc;
    btb_pkg::btb_info_t   update_info;
    logic                 update_hit;
    btb_pkg::way_idx_t    update_hit_way;

    modport sender (
        output update_valid,
        output update_pc,
        output update_info,
        output update_hit,
        output update_hit_way
    );

    modport receiver (
        input update_valid,
        input update_pc,
        input update_info,
        input update_hit,
        input update_hit_way
    );

endinterface

/* logic/plru_updater.sv */
// Tree pseudo-LRU next-state and victim selection for one set
`timescale 1ns/1ps

module plru_updater #(
    parameter int num_entries = 2
) (
    input  btb_pkg::btb_plru_t plru_in,
    input  logic               new_valid,
    output btb_pkg::way_idx_t  new_index,
    input  logic               touch_valid,
    input  btb_pkg::way_idx_t  touch_index,
    output btb_pkg::btb_plru_t plru_out
);

    localparam int levels = $clog2(num_entries);

    // tree layout is heap order, node n has children 2n+1 and 2n+2
    if ((1 << levels) != num_entries || $bits(btb_pkg::btb_plru_t) != num_entries - 1
        || $bits(btb_pkg::way_idx_t) != levels) begin : g_size_check
        $error("plru_updater entry count does not match the set types");
    end

    // each node bit points toward the older half
    always_comb begin
        int node;
        node = 0;
        new_index = '0;
        for (int lvl = 0; lvl < levels; lvl++) begin
            new_index[levels-1-lvl] = plru_in[node];
            node = 2 * node + 1 + int'(plru_in[node]);
        end
    end

    // point every node on the path away from the used entry
    always_comb begin
        int                node;
        btb_pkg::way_idx_t path;
        plru_out = plru_in;
        path = new_valid ? new_index : touch_index;
        node = 0;
        if (new_valid || touch_valid) begin
            for (int lvl = 0; lvl < levels; lvl++) begin
                plru_out[node] = ~path[levels-1-lvl];
                node = 2 * node + 1 + int'(path[levels-1-lvl]);
            end
        end
    end

    // a fill and a touch never come together
    always_comb begin
        a_one_use: assert final (!(new_valid && touch_valid))
            else $error("plru_updater got new_valid and touch_valid together");
    end

endmodule

/* logic/distram_1rport_1wport.sv */
// Distributed RAM for the per-set pseudo-LRU bits
`timescale 1ns/1ps
`include "btb_params.svh"

module distram_1rport_1wport (
    input  logic               CLK,
    input  btb_pkg::btb_idx_t  rindex,
    output btb_pkg::btb_plru_t rdata,
    input  logic               wen,
    input  btb_pkg::btb_idx_t  windex,
    input  btb_pkg::btb_plru_t wdata
);

    localparam int sets = 1 << `BTB_LOG_SETS;

    btb_pkg::btb_plru_t mem [sets];

    // all sets start pointing at way 0
    initial begin
        for (int i = 0; i < sets; i++) begin
            mem[i] = '0;
        end
    end

    // asynchronous read
    assign rdata = mem[rindex];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

endmodule

/* logic/bram_1rport_1wport.sv */
// Block RAM of two-way sets with registered read and byte write enables
`timescale 1ns/1ps
`include "btb_params.svh"

module bram_1rport_1wport (
    input  logic              CLK,
    input  logic              reset,
    input  logic              ren,
    input  btb_pkg::btb_idx_t rindex,
    output btb_pkg::btb_set_t rdata,
    input  logic [7:0]        wen_byte,
    input  btb_pkg::btb_idx_t windex,
    input  btb_pkg::btb_set_t wdata
);

    localparam int sets  = 1 << `BTB_LOG_SETS;
    localparam int bytes = $bits(btb_pkg::btb_set_t) / 8;

    // byte b of a set sits at bits 8b+7 down to 8b
    logic [$bits(btb_pkg::btb_set_t)-1:0] mem [sets];
    logic [$bits(btb_pkg::btb_set_t)-1:0] wdata_bits;

    // zero action everywhere, so every lookup misses
    initial begin
        for (int i = 0; i < sets; i++) begin
            mem[i] = '0;
        end
    end

    assign wdata_bits = wdata;

    // --------------------
    // read port

    // a write to the same index shows up one read later
    always_ff @(posedge CLK) begin
        if (reset) begin
            rdata <= '0;
        end
        else if (ren) begin
            rdata <= mem[rindex];
        end
    end

    // --------------------
    // write port

    always_ff @(posedge CLK) begin
        for (int b = 0; b < bytes; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata_bits[b*8 +: 8];
            end
        end
    end

    a_read_known: assert property (@(posedge CLK) disable iff (reset)
        !$isunknown(ren) && (!ren || !$isunknown(rindex)))
        else $error("bram read port carries unknown values");

endmodule

/* logic/btb.sv */
// Two-way branch target buffer with asid hashing and pseudo-LRU fill
`timescale 1ns/1ps
`include "btb_params.svh"

module btb (
    input  logic                 CLK,
    input  logic                 reset,

    // architectural state
    input  btb_pkg::asid_t       arch_asid,

    // read request, one cycle ahead of the response
    input  logic                 read_req_valid,
    input  btb_pkg::fetch_idx_t  read_req_fetch_index,

    // read response
    input  btb_pkg::pc_t         read_resp_pc,
    output logic                 read_resp_hit,
    output btb_pkg::way_idx_t    read_resp_hit_way,
    output btb_pkg::btb_info_t   read_resp_info,

    // update from the predictor
    btb_update_if.receiver       upd
);

    // --------------------
    // hashing

    function automatic btb_pkg::btb_idx_t index_hash(input btb_pkg::fetch_idx_t fetch_index,
                                                     input btb_pkg::asid_t asid);
        index_hash = fetch_index ^ asid[`BTB_LOG_SETS-1:0];
    endfunction

    // low bits above the index, folded with the asid
    function automatic btb_pkg::btb_tag_t tag_hash(input btb_pkg::pc_t pc,
                                                   input btb_pkg::asid_t asid);
        logic [`BTB_PC_WIDTH-`BTB_LOG_SETS-`BTB_LOG_FETCH_LANES-1:0] upper;
        upper = pc[`BTB_PC_WIDTH-1:`BTB_LOG_SETS+`BTB_LOG_FETCH_LANES];
        tag_hash = upper[`BTB_TAG_WIDTH-1:0] ^ asid[`BTB_TAG_WIDTH-1:0];
    endfunction

    // --------------------
    // signals

    btb_pkg::btb_idx_t   read_index;
    btb_pkg::btb_set_t   read_set;
    btb_pkg::btb_tag_t   resp_tag;
    btb_pkg::lane_t      resp_lane;
    logic [`BTB_ASSOC-1:0] way_hit;

    logic [`BTB_ASSOC-1:0][$bits(btb_pkg::btb_entry_t)/8-1:0] write_byten;
    btb_pkg::btb_idx_t   update_index;
    btb_pkg::btb_set_t   write_set;
    btb_pkg::way_idx_t   selected_way;

    btb_pkg::btb_plru_t  plru_rdata;
    btb_pkg::btb_plru_t  plru_wdata;
    logic                plru_new_valid;
    logic                plru_touch_valid;
    btb_pkg::way_idx_t   plru_new_index;

    // --------------------
    // read path

    assign read_index = index_hash(read_req_fetch_index, arch_asid);
    assign resp_tag   = tag_hash(read_resp_pc, arch_asid);
    assign resp_lane  = btb_pkg::fetch_lane_bits(read_resp_pc);

    // valid entry, same tag, branch at or past the fetch lane
    always_comb begin
        for (int w = 0; w < `BTB_ASSOC; w++) begin
            way_hit[w] = (|read_set[w].info.action)
                       && (read_set[w].tag == resp_tag)
                       && (read_set[w].lane >= resp_lane);
        end
    end

    assign read_resp_hit = |way_hit;

    // select logic written for two ways
    always_comb begin
        if (way_hit[1] && way_hit[0]) begin
            // earlier branch wins, way 1 on a tie
            if (read_set[1].lane <= read_set[0].lane) begin
                read_resp_hit_way = btb_pkg::way_idx_t'(1);
            end
            else begin
                read_resp_hit_way = btb_pkg::way_idx_t'(0);
            end
        end
        else if (way_hit[1]) begin
            read_resp_hit_way = btb_pkg::way_idx_t'(1);
        end
        else begin
            read_resp_hit_way = btb_pkg::way_idx_t'(0);
        end
    end

    assign read_resp_info = read_set[read_resp_hit_way].info;

    // --------------------
    // update path

    assign update_index     = index_hash(btb_pkg::fetch_idx_bits(upd.update_pc), arch_asid);
    assign plru_new_valid   = upd.update_valid && !upd.update_hit;
    assign plru_touch_valid = upd.update_valid && upd.update_hit;
    assign selected_way     = upd.update_hit ? upd.update_hit_way : plru_new_index;

    // same entry offered to every way, byte enables pick one
    always_comb begin
        write_byten = '0;
        if (upd.update_valid) begin
            write_byten[selected_way] = '1;
        end
        for (int w = 0; w < `BTB_ASSOC; w++) begin
            write_set[w].info = upd.update_info;
            write_set[w].tag  = tag_hash(upd.update_pc, arch_asid);
            write_set[w].lane = btb_pkg::fetch_lane_bits(upd.update_pc);
        end
    end

    plru_updater #(
        .num_entries (`BTB_ASSOC)
    ) i_plru_updater (
        .plru_in     (plru_rdata),
        .new_valid   (plru_new_valid),
        .new_index   (plru_new_index),
        .touch_valid (plru_touch_valid),
        .touch_index (upd.update_hit_way),
        .plru_out    (plru_wdata)
    );

    distram_1rport_1wport i_plru_array (
        .CLK    (CLK),
        .rindex (update_index),
        .rdata  (plru_rdata),
        .wen    (upd.update_valid),
        .windex (update_index),
        .wdata  (plru_wdata)
    );

    bram_1rport_1wport i_set_array (
        .CLK      (CLK),
        .reset    (reset),
        .ren      (read_req_valid),
        .rindex   (read_index),
        .rdata    (read_set),
        .wen_byte (write_byten),
        .windex   (update_index),
        .wdata    (write_set)
    );

    // --------------------
    // checks

    a_update_known: assert property (@(posedge CLK) disable iff (reset)
        upd.update_valid |-> !$isunknown({upd.update_pc, upd.update_info,
                                          upd.update_hit, upd.update_hit_way}))
        else $error("update fields unknown while update_valid is high");

    a_hit_needs_valid: assert property (@(posedge CLK) disable iff (reset)
        !upd.update_valid |-> !upd.update_hit)
        else $error("update_hit high without update_valid");

endmodule

/* logic/btb_top.sv */
// Top level of the branch target buffer with plain update ports
`timescale 1ns/1ps

module btb_top (
    input  logic                 CLK,
    input  logic                 reset,

    input  btb_pkg::asid_t       arch_asid,

    // read request
    input  logic                 read_req_valid,
    input  btb_pkg::fetch_idx_t  read_req_fetch_index,

    // read response
    input  btb_pkg::pc_t         read_resp_pc,
    output logic                 read_resp_hit,
    output btb_pkg::way_idx_t    read_resp_hit_way,
    output btb_pkg::btb_info_t   read_resp_info,

    // update
    input  logic                 update_valid,
    input  btb_pkg::pc_t         update_pc,
    input  btb_pkg::btb_info_t   update_info,
    input  logic                 update_hit,
    input  btb_pkg::way_idx_t    update_hit_way
);

    btb_update_if upd_if ();

    // update ports onto the bundle
    assign upd_if.update_valid   = update_valid;
    assign upd_if.update_pc      = update_pc;
    assign upd_if.update_info    = update_info;
    assign upd_if.update_hit     = update_hit;
    assign upd_if.update_hit_way = update_hit_way;

    btb i_btb (
        .CLK                  (CLK),
        .reset                (reset),
        .arch_asid            (arch_asid),
        .read_req_valid       (read_req_valid),
        .read_req_fetch_index (read_req_fetch_index),
        .read_resp_pc         (read_resp_pc),
        .read_resp_hit        (read_resp_hit),
        .read_resp_hit_way    (read_resp_hit_way),
        .read_resp_info       (read_resp_info),
        .upd                  (upd_if.receiver)
    );

endmodule

/* bench/btb_tb.sv */
// Directed testbench for the two-way branch target buffer against a shadow model
`timescale 1ns/1ps
`include "btb_params.svh"

module btb_tb;

    localparam int sets        = 1 << `BTB_LOG_SETS;
    localparam int upper_width = `BTB_PC_WIDTH - `BTB_LOG_SETS - `BTB_LOG_FETCH_LANES;

    // cycle budget per test, a read takes two cycles and an update one
    localparam int reset_cycles     = 8;
    localparam int empty_cycles     = 2 * sets + 4;
    localparam int insert_cycles    = 1 + 2 + 4;
    localparam int lane_cycles      = 1 + 2 * 8 + 4;
    localparam int two_way_cycles   = 5 + 2 * 7 + 4;
    localparam int asid_cycles      = 1 + 2 * 4 + 4;
    localparam int collision_cycles = 1 + 2 + 2 + 4;
    localparam int cycle_limit      = 2 * (reset_cycles + empty_cycles + insert_cycles
                                      + lane_cycles + two_way_cycles + asid_cycles
                                      + collision_cycles);

    typedef logic [upper_width-1:0] upper_t;

    logic                 CLK;
    logic                 reset;
    btb_pkg::asid_t       arch_asid;
    logic                 read_req_valid;
    btb_pkg::fetch_idx_t  read_req_fetch_index;
    btb_pkg::pc_t         read_resp_pc;
    logic                 read_resp_hit;
    btb_pkg::way_idx_t    read_resp_hit_way;
    btb_pkg::btb_info_t   read_resp_info;
    logic                 update_valid;
    btb_pkg::pc_t         update_pc;
    btb_pkg::btb_info_t   update_info;
    logic                 update_hit;
    btb_pkg::way_idx_t    update_hit_way;

    btb_top i_btb_top (
        .CLK                  (CLK),
        .reset                (reset),
        .arch_asid            (arch_asid),
        .read_req_valid       (read_req_valid),
        .read_req_fetch_index (read_req_fetch_index),
        .read_resp_pc         (read_resp_pc),
        .read_resp_hit        (read_resp_hit),
        .read_resp_hit_way    (read_resp_hit_way),
        .read_resp_info       (read_resp_info),
        .update_valid         (update_valid),
        .update_pc            (update_pc),
        .update_info          (update_info),
        .update_hit           (update_hit),
        .update_hit_way       (update_hit_way)
    );

    // shadow copy of the set array and the tree bits
    btb_pkg::btb_set_t  shadow_sets [sets];
    btb_pkg::btb_plru_t shadow_plru [sets];
    int                 cycle_count = 0;
    int                 error_count = 0;

    always #5 CLK = ~CLK;

    // --------------------
    // timeout

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // compare tasks

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "hit mismatch");
        end
    endtask

    task automatic check_way(input string name, input btb_pkg::way_idx_t got,
                             input btb_pkg::way_idx_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "way mismatch");
        end
    endtask

    task automatic check_info(input string name, input btb_pkg::btb_info_t got,
                              input btb_pkg::btb_info_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "info mismatch");
        end
    endtask

    // --------------------
    // shadow model

    function automatic btb_pkg::pc_t make_pc(input upper_t upper,
                                             input btb_pkg::fetch_idx_t fidx,
                                             input btb_pkg::lane_t lane);
        make_pc = {upper, fidx, lane};
    endfunction

    function automatic btb_pkg::btb_info_t random_info();
        btb_pkg::btb_info_t info;
        info.action = `BTB_ACTION_WIDTH'($urandom_range(7, 1));
        info.target = `BTB_TARGET_WIDTH'($urandom);
        return info;
    endfunction

    // set is pc[9:3] folded with asid[6:0]
    function automatic btb_pkg::btb_idx_t set_of(input btb_pkg::pc_t pc,
                                                 input btb_pkg::asid_t asid);
        set_of = pc[9:3] ^ asid[6:0];
    endfunction

    // tag is pc[17:10] folded with asid[7:0]
    function automatic btb_pkg::btb_tag_t tag_of(input btb_pkg::pc_t pc,
                                                 input btb_pkg::asid_t asid);
        tag_of = pc[17:10] ^ asid[7:0];
    endfunction

    task automatic predict_lookup(input btb_pkg::pc_t pc, input btb_pkg::asid_t asid,
                                  output logic hit, output btb_pkg::way_idx_t way,
                                  output btb_pkg::btb_info_t info);
        btb_pkg::btb_set_t set_data;
        logic [1:0]        hits;
        set_data = shadow_sets[set_of(pc, asid)];
        for (int w = 0; w < 2; w++) begin
            hits[w] = (|set_data[w].info.action) && (set_data[w].tag == tag_of(pc, asid))
                    && (set_data[w].lane >= pc[2:0]);
        end
        hit = |hits;
        // lower stored lane wins, way 1 on a tie
        if (hits == 2'b11) begin
            way = (set_data[1].lane <= set_data[0].lane) ? 1'b1 : 1'b0;
        end
        else begin
            way = hits[1];
        end
        info = set_data[way].info;
    endtask

    task automatic record_update(input btb_pkg::pc_t pc, input btb_pkg::asid_t asid,
                                 input btb_pkg::btb_info_t info, input logic hit,
                                 input btb_pkg::way_idx_t hit_way,
                                 output btb_pkg::way_idx_t used);
        btb_pkg::btb_idx_t   idx;
        btb_pkg::btb_entry_t entry;
        idx = set_of(pc, asid);
        // victim is the way the tree bit points at
        used = hit ? hit_way : btb_pkg::way_idx_t'(shadow_plru[idx]);
        entry.info = info;
        entry.tag  = tag_of(pc, asid);
        entry.lane = pc[2:0];
        shadow_sets[idx][used] = entry;
        shadow_plru[idx] = btb_pkg::btb_plru_t'(~used);
    endtask

    // --------------------
    // bus tasks, entered just after a falling edge

    task automatic write_entry(input btb_pkg::pc_t pc, input btb_pkg::btb_info_t info,
                               input logic hit, input btb_pkg::way_idx_t hit_way,
                               output btb_pkg::way_idx_t used);
        update_valid   = 1'b1;
        update_pc      = pc;
        update_info    = info;
        update_hit     = hit;
        update_hit_way = hit_way;
        record_update(pc, arch_asid, info, hit, hit_way, used);
        @(negedge CLK);
        update_valid = 1'b0;
        update_hit   = 1'b0;
    endtask

    task automatic read_entry(input btb_pkg::pc_t pc, output logic hit,
                              output btb_pkg::way_idx_t way, output btb_pkg::btb_info_t info);
        logic               exp_hit;
        btb_pkg::way_idx_t  exp_way;
        btb_pkg::btb_info_t exp_info;
        predict_lookup(pc, arch_asid, exp_hit, exp_way, exp_info);
        read_req_valid       = 1'b1;
        read_req_fetch_index = pc[9:3];
        @(negedge CLK);
        read_req_valid = 1'b0;
        read_resp_pc   = pc;
        #1;
        check_hit("read_resp_hit", read_resp_hit, exp_hit);
        check_way("read_resp_hit_way", read_resp_hit_way, exp_way);
        check_info("read_resp_info", read_resp_info, exp_info);
        hit  = read_resp_hit;
        way  = read_resp_hit_way;
        info = read_resp_info;
        @(negedge CLK);
    endtask

    // read and update strobed together, response should show the old set
    task automatic read_during_update(input btb_pkg::pc_t pc, input btb_pkg::btb_info_t info,
                                      input btb_pkg::way_idx_t hit_way,
                                      output btb_pkg::btb_info_t got);
        logic               exp_hit;
        btb_pkg::way_idx_t  exp_way;
        btb_pkg::btb_info_t exp_info;
        btb_pkg::way_idx_t  used;
        predict_lookup(pc, arch_asid, exp_hit, exp_way, exp_info);
        read_req_valid       = 1'b1;
        read_req_fetch_index = pc[9:3];
        update_valid         = 1'b1;
        update_pc            = pc;
        update_info          = info;
        update_hit           = 1'b1;
        update_hit_way       = hit_way;
        @(negedge CLK);
        read_req_valid = 1'b0;
        update_valid   = 1'b0;
        update_hit     = 1'b0;
        read_resp_pc   = pc;
        #1;
        check_hit("read_resp_hit", read_resp_hit, exp_hit);
        check_way("read_resp_hit_way", read_resp_hit_way, exp_way);
        check_info("read_resp_info", read_resp_info, exp_info);
        got = read_resp_info;
        record_update(pc, arch_asid, info, 1'b1, hit_way, used);
        @(negedge CLK);
    endtask

    // --------------------
    // tests

    task automatic empty_after_reset();
        logic               hit;
        btb_pkg::way_idx_t  way;
        btb_pkg::btb_info_t info;
        check_hit("read_resp_hit", read_resp_hit, 1'b0);
        check_info("read_resp_info", read_resp_info, '0);
        for (int s = 0; s < sets; s++) begin
            read_entry(make_pc(upper_t'($urandom), btb_pkg::fetch_idx_t'(s),
                               btb_pkg::lane_t'($urandom)), hit, way, info);
            check_hit("read_resp_hit", hit, 1'b0);
        end
    endtask

    task automatic insert_and_read();
        btb_pkg::pc_t       pc;
        btb_pkg::btb_info_t info;
        btb_pkg::btb_info_t got;
        btb_pkg::way_idx_t  used;
        btb_pkg::way_idx_t  way;
        logic               hit;
        pc   = make_pc(upper_t'($urandom), 7'h11, btb_pkg::lane_t'($urandom));
        info = random_info();
        write_entry(pc, info, 1'b0, 1'b0, used);
        read_entry(pc, hit, way, got);
        check_hit("read_resp_hit", hit, 1'b1);
        check_way("read_resp_hit_way", way, used);
        check_info("read_resp_info", got, info);
    endtask

    task automatic lane_rule();
        upper_t             upper;
        btb_pkg::btb_info_t info;
        btb_pkg::btb_info_t got;
        btb_pkg::way_idx_t  used;
        btb_pkg::way_idx_t  way;
        logic               hit;
        upper = upper_t'($urandom);
        info  = random_info();
        write_entry(make_pc(upper, 7'h22, 3'd5), info, 1'b0, 1'b0, used);
        for (int l = 0; l < 8; l++) begin
            read_entry(make_pc(upper, 7'h22, btb_pkg::lane_t'(l)), hit, way, got);
            check_hit("read_resp_hit", hit, logic'(l <= 5));
        end
    endtask

    task automatic two_way_select();
        upper_t             u;
        upper_t             v;
        btb_pkg::btb_info_t info_a;
        btb_pkg::btb_info_t info_b;
        btb_pkg::btb_info_t info_c;
        btb_pkg::btb_info_t info_d;
        btb_pkg::btb_info_t info_e;
        btb_pkg::btb_info_t got;
        btb_pkg::way_idx_t  way_a;
        btb_pkg::way_idx_t  way_b;
        btb_pkg::way_idx_t  way_e;
        btb_pkg::way_idx_t  used;
        btb_pkg::way_idx_t  way;
        logic               hit;
        u      = upper_t'($urandom);
        v      = u ^ upper_t'(1);
        info_a = random_info();
        info_b = random_info();
        info_c = random_info();
        info_d = random_info();
        info_e = random_info();
        write_entry(make_pc(u, 7'h33, 3'd6), info_a, 1'b0, 1'b0, way_a);
        write_entry(make_pc(u, 7'h33, 3'd2), info_b, 1'b0, 1'b0, way_b);
        // both hit at lane 0, lane 2 entry is the earlier branch
        read_entry(make_pc(u, 7'h33, 3'd0), hit, way, got);
        check_way("read_resp_hit_way", way, way_b);
        check_info("read_resp_info", got, info_b);
        read_entry(make_pc(u, 7'h33, 3'd4), hit, way, got);
        check_way("read_resp_hit_way", way, way_a);
        check_info("read_resp_info", got, info_a);
        // hit update moves entry a to lane 7, entry b untouched
        write_entry(make_pc(u, 7'h33, 3'd7), info_c, 1'b1, way_a, used);
        read_entry(make_pc(u, 7'h33, 3'd7), hit, way, got);
        check_info("read_resp_info", got, info_c);
        read_entry(make_pc(u, 7'h33, 3'd0), hit, way, got);
        check_info("read_resp_info", got, info_b);
        // equal lanes go to way 1
        write_entry(make_pc(u, 7'h33, 3'd2), info_d, 1'b1, way_a, used);
        read_entry(make_pc(u, 7'h33, 3'd0), hit, way, got);
        check_way("read_resp_hit_way", way, 1'b1);
        // third tag replaces the pseudo-LRU victim
        write_entry(make_pc(v, 7'h33, 3'd4), info_e, 1'b0, 1'b0, way_e);
        read_entry(make_pc(v, 7'h33, 3'd4), hit, way, got);
        check_hit("read_resp_hit", hit, 1'b1);
        check_way("read_resp_hit_way", way, way_e);
        check_info("read_resp_info", got, info_e);
        read_entry(make_pc(u, 7'h33, 3'd0), hit, way, got);
    endtask

    task automatic asid_separation();
        btb_pkg::asid_t     base_asid;
        btb_pkg::pc_t       pc;
        btb_pkg::btb_info_t info;
        btb_pkg::btb_info_t got;
        btb_pkg::way_idx_t  used;
        btb_pkg::way_idx_t  way;
        logic               hit;
        base_asid = arch_asid;
        pc   = make_pc(upper_t'($urandom), 7'h44, 3'd3);
        info = random_info();
        write_entry(pc, info, 1'b0, 1'b0, used);
        read_entry(pc, hit, way, got);
        check_hit("read_resp_hit", hit, 1'b1);
        // same set, tag bit 7 differs
        arch_asid = base_asid ^ 9'h080;
        read_entry(pc, hit, way, got);
        check_hit("read_resp_hit", hit, 1'b0);
        // different set
        arch_asid = base_asid ^ 9'h003;
        read_entry(pc, hit, way, got);
        check_hit("read_resp_hit", hit, 1'b0);
        arch_asid = base_asid;
        read_entry(pc, hit, way, got);
        check_hit("read_resp_hit", hit, 1'b1);
        check_info("read_resp_info", got, info);
    endtask

    task automatic read_write_collision();
        btb_pkg::pc_t       pc;
        btb_pkg::btb_info_t info_x;
        btb_pkg::btb_info_t info_y;
        btb_pkg::btb_info_t got;
        btb_pkg::way_idx_t  way_x;
        btb_pkg::way_idx_t  way;
        logic               hit;
        pc     = make_pc(upper_t'($urandom), 7'h55, 3'd1);
        info_x = random_info();
        info_y = random_info();
        write_entry(pc, info_x, 1'b0, 1'b0, way_x);
        read_during_update(pc, info_y, way_x, got);
        check_info("read_resp_info", got, info_x);
        read_entry(pc, hit, way, got);
        check_info("read_resp_info", got, info_y);
    endtask

    // --------------------
    // main sequence

    initial begin
        int unsigned seed;
        seed = 32'h8c51_8f0e;
        void'($urandom(seed));
        CLK                  = 1'b0;
        reset                = 1'b1;
        arch_asid            = 9'h0a5;
        read_req_valid       = 1'b0;
        read_req_fetch_index = '0;
        read_resp_pc         = '0;
        update_valid         = 1'b0;
        update_pc            = '0;
        update_info          = '0;
        update_hit           = 1'b0;
        update_hit_way       = '0;
        for (int i = 0; i < sets; i++) begin
            shadow_sets[i] = '0;
            shadow_plru[i] = '0;
        end
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;

        empty_after_reset();
        insert_and_read();
        lane_rule();
        two_way_select();
        asid_separation();
        read_write_collision();

        if (error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end
        else begin
            $display("TESTS FAILED");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

/* branch_target_buffer.f */
+incdir+logic
logic/btb_pkg.sv
logic/btb_update_if.sv
logic/plru_updater.sv
logic/distram_1rport_1wport.sv
logic/bram_1rport_1wport.sv
logic/btb.sv
logic/btb_top.sv
bench/btb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the branch target buffer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f branch_target_buffer.f \
    --top-module btb_tb \
    -o btb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/btb_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit "$sim_status"
fi

exit 0
